/* vlog.f */
logic/soc_map_pkg.sv
logic/camd_pkg.sv
logic/camd_ram.sv
logic/camd_port_arbiter.sv
logic/camd_addr_decode.sv
logic/camd_console.sv
logic/camd_mem_sys.sv
sim/camd_mem_sys_checker.sv
sim/camd_mem_sys_tb.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= camd_mem_sys_tb
FLIST     ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

test: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/camd_mem_sys_tb.sv */
`timescale 1ns/10ps

module camd_mem_sys_tb;

   localparam int CYCLES_PER_OP = 64;
   localparam int NUM_TESTS     = 5;

   // One bus operation with the value a read must return
   typedef struct packed {
      logic [3:0]      test;
      camd_pkg::port_e port;
      camd_pkg::ca_t   ca;
      camd_pkg::dm_t   dm;
      camd_pkg::data_t exp;
   } op_t;

   logic            clk;
   logic            i_rst;
   camd_pkg::ca_t   i_i_ca;
   logic            i_i_ca_vld;
   logic            o_i_ca_rdy;
   camd_pkg::data_t o_i_rd_dat;
   logic            o_i_rd_vld;
   logic            i_i_rd_rdy;
   camd_pkg::ca_t   i_d_ca;
   logic            i_d_ca_vld;
   logic            o_d_ca_rdy;
   camd_pkg::dm_t   i_d_dm;
   logic            i_d_dm_vld;
   logic            o_d_dm_rdy;
   camd_pkg::data_t o_d_rd_dat;
   logic            o_d_rd_vld;
   logic            i_d_rd_rdy;
   logic [7:0]      o_con_char;
   logic            o_con_vld;

   op_t             ops[$];
   camd_pkg::data_t model [soc_map_pkg::widx_t];
   camd_pkg::data_t exp_i[$];
   camd_pkg::data_t exp_d[$];
   logic [7:0]      exp_con[$];
   integer          seed;
   logic            bp_on;
   int              err_cnt;
   int              fail_tests;

   camd_mem_sys u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // Reference memory applies the byte-mask merge and skips the console address
   function automatic void add_op(input int t, input camd_pkg::port_e p, input logic wr,
                                  input soc_map_pkg::addr_t adr, input camd_pkg::data_t dat,
                                  input camd_pkg::msk_t msk);
      op_t                o;
      soc_map_pkg::widx_t w;
      camd_pkg::data_t    word;
      w        = soc_map_pkg::widx_t'((adr >> 2) % soc_map_pkg::RAM_WORDS);
      word     = model.exists(w) ? model[w] : '0;
      o.test   = 4'(t);
      o.port   = p;
      o.ca.wr  = wr;
      o.ca.adr = adr;
      o.dm.dat = dat;
      o.dm.msk = msk;
      o.exp    = '0;
      if (adr == soc_map_pkg::CONSOLE_ADR) begin
         if (wr && msk[0])
            exp_con.push_back(dat[7:0]);
      end else if (wr) begin
         for (int b = 0; b < camd_pkg::MSK_W; b++) begin
            if (msk[b])
               word[8*b +: 8] = dat[8*b +: 8];
         end
         model[w] = word;
      end else begin
         o.exp = word;
      end
      ops.push_back(o);
   endfunction

   task automatic build_table();
      camd_pkg::data_t r;
      for (int k = 0; k < 6; k++)
         add_op(1, camd_pkg::PORT_D, 1'b1, 32'(4 * k), 32'h1111_1111 * 32'(k + 1), 4'hF);
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_0FFC, 32'hCAFE_F00D, 4'hF);
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_0004, 32'hA5A5_A5A5, 4'b0011);
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_0008, 32'hDEAD_BEEF, 4'b1100);
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_000C, 32'h1234_5678, 4'b0101);
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_0010, 32'hFFFF_FFFF, 4'b0000);
      // Address above the RAM size wraps onto word 5
      add_op(1, camd_pkg::PORT_D, 1'b1, 32'h0000_1014, 32'h7700_0000, 4'b1000);
      for (int k = 0; k < 6; k++)
         add_op(1, camd_pkg::PORT_D, 1'b0, 32'(4 * k), '0, '0);
      add_op(1, camd_pkg::PORT_D, 1'b0, 32'h0000_0FFC, '0, '0);
      for (int k = 0; k < 6; k++)
         add_op(2, camd_pkg::PORT_I, 1'b0, 32'(4 * k), '0, '0);
      add_op(2, camd_pkg::PORT_I, 1'b0, 32'h0000_0FFC, '0, '0);
      for (int k = 0; k < 4; k++) begin
         add_op(3, camd_pkg::PORT_I, 1'b0, 32'(4 * k), '0, '0);
         add_op(3, camd_pkg::PORT_D, 1'b0, 32'(4 * (5 - k)), '0, '0);
      end
      // Data port fills fresh words while the instruction port rereads old ones
      for (int k = 0; k < 16; k++) begin
         r = $random(seed);
         add_op(4, camd_pkg::PORT_D, 1'b1, 32'h80 + 32'(4 * k), r, 4'hF);
      end
      for (int k = 0; k < 16; k++) begin
         add_op(4, camd_pkg::PORT_D, 1'b0, 32'h80 + 32'(4 * k), '0, '0);
         add_op(4, camd_pkg::PORT_I, 1'b0, 32'(4 * (k % 6)), '0, '0);
      end
      add_op(5, camd_pkg::PORT_D, 1'b1, soc_map_pkg::CONSOLE_ADR, 32'h0000_0048, 4'b0001);
      add_op(5, camd_pkg::PORT_D, 1'b1, soc_map_pkg::CONSOLE_ADR, 32'h5858_5858, 4'b1110);
      add_op(5, camd_pkg::PORT_D, 1'b1, soc_map_pkg::CONSOLE_ADR, 32'hFFFF_FF69, 4'b1111);
      add_op(5, camd_pkg::PORT_D, 1'b0, 32'h0000_0004, '0, '0);
      add_op(5, camd_pkg::PORT_D, 1'b0, soc_map_pkg::CONSOLE_ADR, '0, '0);
      add_op(5, camd_pkg::PORT_D, 1'b1, soc_map_pkg::CONSOLE_ADR, 32'h0000_0021, 4'b0001);
      add_op(5, camd_pkg::PORT_D, 1'b0, 32'h0000_0000, '0, '0);
   endtask

   task automatic report_test(input int t, input string name, input int errs);
      if (errs == 0) begin
         $display("Test %0d (%s): ok", t, name);
      end else begin
         $display("Test %0d (%s): %0d errors", t, name, errs);
         fail_tests++;
      end
   endtask

   task automatic check_idle();
      check_value("o_i_ca_rdy", 32'(o_i_ca_rdy), 32'h0);
      check_value("o_i_rd_vld", 32'(o_i_rd_vld), 32'h0);
      check_value("o_d_ca_rdy", 32'(o_d_ca_rdy), 32'h0);
      check_value("o_d_dm_rdy", 32'(o_d_dm_rdy), 32'h0);
      check_value("o_d_rd_vld", 32'(o_d_rd_vld), 32'h0);
      check_value("o_con_vld", 32'(o_con_vld), 32'h0);
   endtask

   task automatic reset_test();
      int err_before;
      err_before = err_cnt;
      repeat (2) @(posedge clk);
      // Requests already waiting when reset ends must not be taken
      i_i_ca     <= '{wr: 1'b0, adr: 32'h0000_0040};
      i_i_ca_vld <= 1'b1;
      i_d_ca     <= '{wr: 1'b1, adr: 32'h0000_0044};
      i_d_ca_vld <= 1'b1;
      i_d_dm     <= '{dat: 32'h0BAD_0BAD, msk: 4'hF};
      i_d_dm_vld <= 1'b1;
      repeat (5) begin
         @(negedge clk);
         check_idle();
      end
      repeat (2) @(posedge clk);
      i_rst <= 1'b0;
      @(negedge clk);
      check_idle();
      @(posedge clk);
      i_i_ca_vld <= 1'b0;
      i_d_ca_vld <= 1'b0;
      i_d_dm_vld <= 1'b0;
      report_test(0, "reset", err_cnt - err_before);
   endtask

   task automatic wait_accept(input camd_pkg::port_e p, input logic wr);
      logic rdy;
      rdy = 1'b0;
      while (!rdy) begin
         @(negedge clk);
         rdy = (p == camd_pkg::PORT_I) ? o_i_ca_rdy : o_d_ca_rdy;
      end
      // Both write channels move in the same cycle
      if (wr)
         check_value("o_d_dm_rdy", 32'(o_d_dm_rdy), 32'h1);
   endtask

   task automatic issue_port(input int t, input camd_pkg::port_e p);
      foreach (ops[k]) begin
         if (ops[k].test == 4'(t) && ops[k].port == p) begin
            @(posedge clk);
            if (p == camd_pkg::PORT_I) begin
               i_i_ca     <= ops[k].ca;
               i_i_ca_vld <= 1'b1;
            end else begin
               i_d_ca     <= ops[k].ca;
               i_d_ca_vld <= 1'b1;
               i_d_dm     <= ops[k].dm;
               i_d_dm_vld <= ops[k].ca.wr;
            end
            wait_accept(p, ops[k].ca.wr);
         end
      end
      @(posedge clk);
      if (p == camd_pkg::PORT_I) begin
         i_i_ca_vld <= 1'b0;
      end else begin
         i_d_ca_vld <= 1'b0;
         i_d_dm_vld <= 1'b0;
      end
   endtask

   task automatic run_test(input int t, input string name);
      int err_before;
      err_before = err_cnt;
      @(posedge clk);
      bp_on <= (t == 4);
      foreach (ops[k]) begin
         if (ops[k].test == 4'(t) && !ops[k].ca.wr) begin
            if (ops[k].port == camd_pkg::PORT_I)
               exp_i.push_back(ops[k].exp);
            else
               exp_d.push_back(ops[k].exp);
         end
      end
      fork
         issue_port(t, camd_pkg::PORT_I);
         issue_port(t, camd_pkg::PORT_D);
      join
      while (exp_i.size() != 0 || exp_d.size() != 0)
         @(negedge clk);
      // Last console strobe lands a cycle after its write
      repeat (2) @(negedge clk);
      if (t == NUM_TESTS && exp_con.size() != 0) begin
         $display("Console output is missing %0d characters", exp_con.size());
         err_cnt++;
      end
      report_test(t, name, err_cnt - err_before);
   endtask

   task automatic run_watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("SOME TESTS FAILED");
      $finish;
   endtask

   // Read-ready stays high except during the back-pressure test
   initial begin
      logic [31:0] rnd;
      forever begin
         @(posedge clk);
         rnd = $random(seed);
         i_i_rd_rdy <= bp_on ? rnd[0] : 1'b1;
         i_d_rd_rdy <= bp_on ? rnd[1] : 1'b1;
      end
   end

   // Responses are taken at the next rising edge when valid and ready
   initial begin
      forever begin
         @(negedge clk);
         if (!i_rst && o_i_rd_vld && i_i_rd_rdy) begin
            if (exp_i.size() == 0) begin
               $display("Unexpected read response on the instruction port");
               err_cnt++;
            end else begin
               check_value("o_i_rd_dat", o_i_rd_dat, exp_i.pop_front());
            end
         end
         if (!i_rst && o_d_rd_vld && i_d_rd_rdy) begin
            if (exp_d.size() == 0) begin
               $display("Unexpected read response on the data port");
               err_cnt++;
            end else begin
               check_value("o_d_rd_dat", o_d_rd_dat, exp_d.pop_front());
            end
         end
         if (!i_rst && o_con_vld) begin
            if (exp_con.size() == 0) begin
               $display("Unexpected character on the console output");
               err_cnt++;
            end else begin
               check_value("o_con_char", 32'(o_con_char), 32'(exp_con.pop_front()));
            end
         end
      end
   end

   initial begin
      seed       = 14865;
      i_rst      = 1'b1;
      i_i_ca     = '0;
      i_i_ca_vld = 1'b0;
      i_i_rd_rdy = 1'b0;
      i_d_ca     = '0;
      i_d_ca_vld = 1'b0;
      i_d_dm     = '0;
      i_d_dm_vld = 1'b0;
      i_d_rd_rdy = 1'b0;
      bp_on      = 1'b0;
      err_cnt    = 0;
      fail_tests = 0;
      build_table();
      fork
         run_watchdog(ops.size() * CYCLES_PER_OP + 16);
      join_none
      reset_test();
      run_test(1, "masked writes and data reads");
      run_test(2, "instruction reads");
      run_test(3, "simultaneous reads");
      run_test(4, "read back-pressure");
      run_test(5, "console");
      $display("Summary: %0d tests, %0d failed, %0d errors",
               NUM_TESTS + 1, fail_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* sim/camd_mem_sys_checker.sv */
`timescale 1ns/10ps

module camd_mem_sys_checker (
   input logic            clk,
   input logic            i_rst,
   input camd_pkg::ca_t   i_i_ca,
   input logic            i_i_ca_vld,
   input logic            o_i_ca_rdy,
   input camd_pkg::data_t o_i_rd_dat,
   input logic            o_i_rd_vld,
   input logic            i_i_rd_rdy,
   input camd_pkg::ca_t   i_d_ca,
   input logic            i_d_ca_vld,
   input logic            o_d_ca_rdy,
   input camd_pkg::dm_t   i_d_dm,
   input logic            i_d_dm_vld,
   input logic            o_d_dm_rdy,
   input camd_pkg::data_t o_d_rd_dat,
   input logic            o_d_rd_vld,
   input logic            i_d_rd_rdy,
   input logic            o_con_vld
);

   // Payloads hold while a transfer is stalled
   a_i_ca_hold: assert property (@(posedge clk) disable iff (i_rst)
      i_i_ca_vld && !o_i_ca_rdy |=> $stable(i_i_ca))
      else $error("instruction command changed while stalled");

   a_d_ca_hold: assert property (@(posedge clk) disable iff (i_rst)
      i_d_ca_vld && !o_d_ca_rdy |=> $stable(i_d_ca))
      else $error("data command changed while stalled");

   a_d_dm_hold: assert property (@(posedge clk) disable iff (i_rst)
      i_d_dm_vld && !o_d_dm_rdy |=> $stable(i_d_dm))
      else $error("write data changed while stalled");

   a_i_rd_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_i_rd_vld && !i_i_rd_rdy |=> o_i_rd_vld && $stable(o_i_rd_dat))
      else $error("instruction read response dropped or changed");

   a_d_rd_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_d_rd_vld && !i_d_rd_rdy |=> o_d_rd_vld && $stable(o_d_rd_dat))
      else $error("data read response dropped or changed");

   a_rd_quiet: assert property (@(posedge clk)
      $fell(i_rst) |-> !o_i_rd_vld && !o_d_rd_vld)
      else $error("read valid in the first cycle after reset");

   a_con_pulse: assert property (@(posedge clk) disable iff (i_rst)
      o_con_vld |=> !o_con_vld)
      else $error("console strobe longer than one cycle");

endmodule

bind camd_mem_sys camd_mem_sys_checker u_checker (.*);

/* logic/camd_mem_sys.sv */
`timescale 1ns/10ps

module camd_mem_sys (
   input  logic            clk,
   input  logic            i_rst,
   // Instruction port
   input  camd_pkg::ca_t   i_i_ca,
   input  logic            i_i_ca_vld,
   output logic            o_i_ca_rdy,
   output camd_pkg::data_t o_i_rd_dat,
   output logic            o_i_rd_vld,
   input  logic            i_i_rd_rdy,
   // Data port
   input  camd_pkg::ca_t   i_d_ca,
   input  logic            i_d_ca_vld,
   output logic            o_d_ca_rdy,
   input  camd_pkg::dm_t   i_d_dm,
   input  logic            i_d_dm_vld,
   output logic            o_d_dm_rdy,
   output camd_pkg::data_t o_d_rd_dat,
   output logic            o_d_rd_vld,
   input  logic            i_d_rd_rdy,
   // Console output
   output logic [7:0]      o_con_char,
   output logic            o_con_vld
);

   // Decoder to arbiter
   camd_pkg::ca_t   dec_ca;
   logic            dec_ca_vld;
   logic            dec_ca_rdy;
   camd_pkg::dm_t   dec_dm;
   logic            dec_dm_vld;
   logic            dec_dm_rdy;
   camd_pkg::data_t dec_rd_dat;
   logic            dec_rd_vld;
   logic            dec_rd_rdy;

   // Arbiter to RAM
   camd_pkg::ca_t   m_ca;
   logic            m_ca_vld;
   logic            m_ca_rdy;
   camd_pkg::dm_t   m_dm;
   logic            m_dm_vld;
   logic            m_dm_rdy;
   camd_pkg::data_t m_rd_dat;
   logic            m_rd_vld;
   logic            m_rd_rdy;

   camd_pkg::dm_t   con_dm;
   logic            con_vld;

   camd_addr_decode u_decode (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ca       (i_d_ca),
      .i_ca_vld   (i_d_ca_vld),
      .o_ca_rdy   (o_d_ca_rdy),
      .i_dm       (i_d_dm),
      .i_dm_vld   (i_d_dm_vld),
      .o_dm_rdy   (o_d_dm_rdy),
      .o_rd_dat   (o_d_rd_dat),
      .o_rd_vld   (o_d_rd_vld),
      .i_rd_rdy   (i_d_rd_rdy),
      .o_m_ca     (dec_ca),
      .o_m_ca_vld (dec_ca_vld),
      .i_m_ca_rdy (dec_ca_rdy),
      .o_m_dm     (dec_dm),
      .o_m_dm_vld (dec_dm_vld),
      .i_m_dm_rdy (dec_dm_rdy),
      .i_m_rd_dat (dec_rd_dat),
      .i_m_rd_vld (dec_rd_vld),
      .o_m_rd_rdy (dec_rd_rdy),
      .o_c_dm     (con_dm),
      .o_c_vld    (con_vld)
   );

   camd_console u_console (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_dm       (con_dm),
      .i_vld      (con_vld),
      .o_con_char (o_con_char),
      .o_con_vld  (o_con_vld)
   );

   camd_port_arbiter u_arbiter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_i_ca     (i_i_ca),
      .i_i_ca_vld (i_i_ca_vld),
      .o_i_ca_rdy (o_i_ca_rdy),
      .o_i_rd_dat (o_i_rd_dat),
      .o_i_rd_vld (o_i_rd_vld),
      .i_i_rd_rdy (i_i_rd_rdy),
      .i_d_ca     (dec_ca),
      .i_d_ca_vld (dec_ca_vld),
      .o_d_ca_rdy (dec_ca_rdy),
      .i_d_dm     (dec_dm),
      .i_d_dm_vld (dec_dm_vld),
      .o_d_dm_rdy (dec_dm_rdy),
      .o_d_rd_dat (dec_rd_dat),
      .o_d_rd_vld (dec_rd_vld),
      .i_d_rd_rdy (dec_rd_rdy),
      .o_m_ca     (m_ca),
      .o_m_ca_vld (m_ca_vld),
      .i_m_ca_rdy (m_ca_rdy),
      .o_m_dm     (m_dm),
      .o_m_dm_vld (m_dm_vld),
      .i_m_dm_rdy (m_dm_rdy),
      .i_m_rd_dat (m_rd_dat),
      .i_m_rd_vld (m_rd_vld),
      .o_m_rd_rdy (m_rd_rdy)
   );

   camd_ram u_ram (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_ca     (m_ca),
      .i_ca_vld (m_ca_vld),
      .o_ca_rdy (m_ca_rdy),
      .i_dm     (m_dm),
      .i_dm_vld (m_dm_vld),
      .o_dm_rdy (m_dm_rdy),
      .o_rd_dat (m_rd_dat),
      .o_rd_vld (m_rd_vld),
      .i_rd_rdy (m_rd_rdy)
   );

endmodule

/* logic/camd_console.sv */
`timescale 1ns/10ps

module camd_console (
   input  logic          clk,
   input  logic          i_rst,
   input  camd_pkg::dm_t i_dm,
   input  logic          i_vld,
   output logic [7:0]    o_con_char,
   output logic          o_con_vld
);

   logic emit;

   // Only a write that enables byte 0 carries a character
   assign emit = i_vld & i_dm.msk[0];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_con_vld <= 1'b0;
      end else begin
         o_con_vld <= emit;
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         o_con_char <= i_dm.dat[7:0];
      end
   end

endmodule

/* logic/camd_addr_decode.sv */
`timescale 1ns/10ps

module camd_addr_decode (
   input  logic            clk,
   input  logic            i_rst,
   // Core side
   input  camd_pkg::ca_t   i_ca,
   input  logic            i_ca_vld,
   output logic            o_ca_rdy,
   input  camd_pkg::dm_t   i_dm,
   input  logic            i_dm_vld,
   output logic            o_dm_rdy,
   output camd_pkg::data_t o_rd_dat,
   output logic            o_rd_vld,
   input  logic            i_rd_rdy,
   // Memory side
   output camd_pkg::ca_t   o_m_ca,
   output logic            o_m_ca_vld,
   input  logic            i_m_ca_rdy,
   output camd_pkg::dm_t   o_m_dm,
   output logic            o_m_dm_vld,
   input  logic            i_m_dm_rdy,
   input  camd_pkg::data_t i_m_rd_dat,
   input  logic            i_m_rd_vld,
   output logic            o_m_rd_rdy,
   // Console side
   output camd_pkg::dm_t   o_c_dm,
   output logic            o_c_vld
);

   logic [camd_pkg::TAG_AW:0] out_cnt_q;

   logic live_q;
   logic con_pend_q;
   logic open_gate;
   logic hit;
   logic m_rd_issue;
   logic m_rd_done;
   logic con_rd_acc;
   logic con_rd_done;

   assign hit = (i_ca.adr == soc_map_pkg::CONSOLE_ADR);

   // No new commands while the console read response is pending
   assign open_gate = live_q & ~con_pend_q;

   assign o_m_ca     = i_ca;
   assign o_m_ca_vld = i_ca_vld & ~hit & open_gate;
   assign o_m_dm     = i_dm;
   assign o_m_dm_vld = i_dm_vld & ~hit & open_gate;

   always_comb begin
      if (hit && i_ca.wr) begin
         o_ca_rdy = open_gate & i_dm_vld;
         o_dm_rdy = open_gate & i_ca_vld;
      end else if (hit) begin
         // Console read only once all memory reads have returned
         o_ca_rdy = open_gate & (out_cnt_q == '0);
         o_dm_rdy = 1'b0;
      end else begin
         o_ca_rdy = open_gate & i_m_ca_rdy;
         o_dm_rdy = open_gate & i_m_dm_rdy;
      end
   end

   assign o_c_dm  = i_dm;
   assign o_c_vld = hit & i_ca.wr & i_ca_vld & i_dm_vld & open_gate;

   assign o_rd_vld   = con_pend_q | i_m_rd_vld;
   assign o_rd_dat   = con_pend_q ? '0 : i_m_rd_dat;
   assign o_m_rd_rdy = i_rd_rdy & ~con_pend_q;

   assign m_rd_issue  = o_m_ca_vld & i_m_ca_rdy & ~i_ca.wr;
   assign m_rd_done   = i_m_rd_vld & o_m_rd_rdy;
   assign con_rd_acc  = i_ca_vld & o_ca_rdy & hit & ~i_ca.wr;
   assign con_rd_done = con_pend_q & i_rd_rdy;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         live_q     <= 1'b0;
         con_pend_q <= 1'b0;
         out_cnt_q  <= '0;
      end else begin
         live_q <= 1'b1;
         if (con_rd_acc) begin
            con_pend_q <= 1'b1;
         end else if (con_rd_done) begin
            con_pend_q <= 1'b0;
         end
         case ({m_rd_issue, m_rd_done})
            2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
            2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
            default: out_cnt_q <= out_cnt_q;
         endcase
      end
   end

endmodule

/* logic/camd_port_arbiter.sv */
`timescale 1ns/10ps

module camd_port_arbiter (
   input  logic            clk,
   input  logic            i_rst,
   // Instruction side
   input  camd_pkg::ca_t   i_i_ca,
   input  logic            i_i_ca_vld,
   output logic            o_i_ca_rdy,
   output camd_pkg::data_t o_i_rd_dat,
   output logic            o_i_rd_vld,
   input  logic            i_i_rd_rdy,
   // Data side
   input  camd_pkg::ca_t   i_d_ca,
   input  logic            i_d_ca_vld,
   output logic            o_d_ca_rdy,
   input  camd_pkg::dm_t   i_d_dm,
   input  logic            i_d_dm_vld,
   output logic            o_d_dm_rdy,
   output camd_pkg::data_t o_d_rd_dat,
   output logic            o_d_rd_vld,
   input  logic            i_d_rd_rdy,
   // RAM side
   output camd_pkg::ca_t   o_m_ca,
   output logic            o_m_ca_vld,
   input  logic            i_m_ca_rdy,
   output camd_pkg::dm_t   o_m_dm,
   output logic            o_m_dm_vld,
   input  logic            i_m_dm_rdy,
   input  camd_pkg::data_t i_m_rd_dat,
   input  logic            i_m_rd_vld,
   output logic            o_m_rd_rdy
);

   // Owner of each read in flight, oldest at the head
   camd_pkg::port_e tag_q [camd_pkg::TAG_DEPTH];

   logic [camd_pkg::TAG_AW-1:0] tag_wr_q;
   logic [camd_pkg::TAG_AW-1:0] tag_rd_q;
   logic [camd_pkg::TAG_AW:0]   tag_cnt_q;

   camd_pkg::port_e grant;
   camd_pkg::port_e prio_q;
   camd_pkg::port_e head;

   logic tag_full;
   logic req_i;
   logic req_d;
   logic m_xfer;
   logic tag_push;
   logic tag_pop;

   assign tag_full = (tag_cnt_q == (camd_pkg::TAG_AW+1)'(camd_pkg::TAG_DEPTH));

   // Reads wait while the tag FIFO is full, writes do not
   assign req_i = i_i_ca_vld & ~tag_full;
   assign req_d = i_d_ca_vld & (i_d_ca.wr | ~tag_full);

   always_comb begin
      if (req_i && req_d) begin
         grant = prio_q;
      end else if (req_d) begin
         grant = camd_pkg::PORT_D;
      end else begin
         grant = camd_pkg::PORT_I;
      end
   end

   assign o_m_ca     = (grant == camd_pkg::PORT_D) ? i_d_ca : i_i_ca;
   assign o_m_ca_vld = (grant == camd_pkg::PORT_D) ? req_d : req_i;
   assign o_m_dm     = i_d_dm;
   assign o_m_dm_vld = (grant == camd_pkg::PORT_D) & req_d & i_d_dm_vld;

   assign o_i_ca_rdy = (grant == camd_pkg::PORT_I) & req_i & i_m_ca_rdy;
   assign o_d_ca_rdy = (grant == camd_pkg::PORT_D) & req_d & i_m_ca_rdy;
   assign o_d_dm_rdy = (grant == camd_pkg::PORT_D) & req_d & i_m_dm_rdy;

   assign m_xfer   = o_m_ca_vld & i_m_ca_rdy;
   assign tag_push = m_xfer & ~o_m_ca.wr;

   // Response goes to the port at the head of the tag FIFO
   assign head       = tag_q[tag_rd_q];
   assign o_i_rd_dat = i_m_rd_dat;
   assign o_d_rd_dat = i_m_rd_dat;
   assign o_i_rd_vld = i_m_rd_vld & (head == camd_pkg::PORT_I);
   assign o_d_rd_vld = i_m_rd_vld & (head == camd_pkg::PORT_D);
   assign o_m_rd_rdy = (head == camd_pkg::PORT_D) ? i_d_rd_rdy : i_i_rd_rdy;
   assign tag_pop    = i_m_rd_vld & o_m_rd_rdy;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         prio_q    <= camd_pkg::PORT_I;
         tag_wr_q  <= '0;
         tag_rd_q  <= '0;
         tag_cnt_q <= '0;
      end else begin
         // Last winner yields to the other port
         if (m_xfer) begin
            prio_q <= (grant == camd_pkg::PORT_I) ? camd_pkg::PORT_D : camd_pkg::PORT_I;
         end
         if (tag_push) begin
            tag_wr_q <= tag_wr_q + 1'b1;
         end
         if (tag_pop) begin
            tag_rd_q <= tag_rd_q + 1'b1;
         end
         case ({tag_push, tag_pop})
            2'b10:   tag_cnt_q <= tag_cnt_q + 1'b1;
            2'b01:   tag_cnt_q <= tag_cnt_q - 1'b1;
            default: tag_cnt_q <= tag_cnt_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (tag_push) begin
         tag_q[tag_wr_q] <= grant;
      end
   end

endmodule

/* logic/camd_ram.sv */
`timescale 1ns/10ps

module camd_ram (
   input  logic            clk,
   input  logic            i_rst,
   input  camd_pkg::ca_t   i_ca,
   input  logic            i_ca_vld,
   output logic            o_ca_rdy,
   input  camd_pkg::dm_t   i_dm,
   input  logic            i_dm_vld,
   output logic            o_dm_rdy,
   output camd_pkg::data_t o_rd_dat,
   output logic            o_rd_vld,
   input  logic            i_rd_rdy
);

   camd_pkg::data_t mem [soc_map_pkg::RAM_WORDS];

   // Read responses wait here until the requester takes them
   camd_pkg::data_t rsp_q [camd_pkg::RSP_DEPTH];

   logic [camd_pkg::RSP_AW-1:0] wr_ptr_q;
   logic [camd_pkg::RSP_AW-1:0] rd_ptr_q;
   logic [camd_pkg::RSP_AW:0]   cnt_q;

   logic               live_q;
   logic               full;
   logic               wr_en;
   logic               rd_push;
   logic               rd_pop;
   soc_map_pkg::widx_t idx;

   // Word index wraps modulo the RAM depth
   assign idx = i_ca.adr[soc_map_pkg::RAM_AW+1:2];

   assign full = (cnt_q == (camd_pkg::RSP_AW+1)'(camd_pkg::RSP_DEPTH));

   // A write needs both channels at once, a read needs buffer room
   assign o_ca_rdy = live_q & (i_ca.wr ? i_dm_vld : ~full);
   assign o_dm_rdy = live_q & i_ca_vld & i_ca.wr;

   assign wr_en   = i_ca_vld & o_ca_rdy & i_ca.wr;
   assign rd_push = i_ca_vld & o_ca_rdy & ~i_ca.wr;

   assign o_rd_vld = (cnt_q != '0);
   assign o_rd_dat = rsp_q[rd_ptr_q];
   assign rd_pop   = o_rd_vld & i_rd_rdy;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         live_q   <= 1'b0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         live_q <= 1'b1;
         if (rd_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({rd_push, rd_pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;
         endcase
      end
   end

   // Byte lanes with a set mask bit replace the stored bytes
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < camd_pkg::MSK_W; b++) begin
            if (i_dm.msk[b]) begin
               mem[idx][8*b +: 8] <= i_dm.dat[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_push) begin
         rsp_q[wr_ptr_q] <= mem[idx];
      end
   end

endmodule

/* logic/camd_pkg.sv */
package camd_pkg;

   localparam int DATA_W = 32;
   localparam int MSK_W  = DATA_W / 8;

   // Reads in flight tracked by the arbiter
   localparam int TAG_DEPTH = 4;
   localparam int TAG_AW    = $clog2(TAG_DEPTH);

   // RAM read response buffer
   localparam int RSP_DEPTH = 2;
   localparam int RSP_AW    = $clog2(RSP_DEPTH);

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [MSK_W-1:0]  msk_t;

   // Command channel payload
   typedef struct packed {
      logic               wr;
      soc_map_pkg::addr_t adr;
   } ca_t;

   // Write-data channel payload
   typedef struct packed {
      data_t dat;
      msk_t  msk;
   } dm_t;

   typedef enum logic {
      PORT_I = 1'b0,
      PORT_D = 1'b1
   } port_e;

endpackage

/* logic/soc_map_pkg.sv */
package soc_map_pkg;

   // Byte addressed bus
   localparam int ADDR_W = 32;

   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   typedef logic [ADDR_W-1:0] addr_t;

   // Word index into the RAM, taken from the byte address
   typedef logic [RAM_AW-1:0] widx_t;

   // Data writes here go to the console sink
   localparam addr_t CONSOLE_ADR = 32'h1000_0000;

endpackage
